/* list.f */
rtl/core_pkg.sv
rtl/instr_buffer.sv
rtl/decode_issue.sv
rtl/dispatch_stage.sv
rtl/exec_stage.sv
rtl/regfile.sv
rtl/cpu_core.sv
bench/cpu_core_sva.sv
bench/cpu_core_tb.sv

/* run.sh */
#!/bin/sh
verilator --binary --timing -Wno-fatal --top-module cpu_core_tb -f list.f -o sim_cpu_core > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_cpu_core > sim.log 2>&1 ; cat sim.log
grep -qx "Regression passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* bench/cpu_core_tb.sv */
`timescale 1ns/10ps

module cpu_core_tb
    import core_pkg::*;
();

    localparam int N_ROWS   = 5;
    localparam int ROW_MAX  = 8;
    localparam int N_RANDOM = 64;
    localparam int TIMEOUT  = 500;

    // One expected commit plus the sources needed for the pairing check
    typedef struct packed {
        commit_t   c;
        op_e       op;
        reg_addr_t rj;
        reg_addr_t rk;
    } exp_t;

    logic                          clk = 1'b0;
    logic                          reset_i;
    fetch_slot_t [FETCH_WIDTH-1:0] fetch_i;
    credit_t                       credit_o;
    commit_t     [ISSUE_WIDTH-1:0] commit_o;

    instr_t    prog_tab [N_ROWS][ROW_MAX];
    int        prog_len [N_ROWS];
    reg_addr_t chk_reg  [N_ROWS];
    word_t     chk_val  [N_ROWS];

    word_t       shadow    [32];
    word_t       committed [32];
    exp_t        exp_q [$];
    fetch_slot_t pend_q [$];
    logic [31:0] lfsr_q       = 32'hdea9_df74;
    word_t       pc_next      = '0;
    int          credits      = IB_DEPTH;
    int          total_sent   = 0;
    int          total_credit = 0;
    int          total_commit = 0;
    int          total_pairs  = 0;

    cpu_core #(
        .FETCH_WIDTH(FETCH_WIDTH),
        .IB_DEPTH   (IB_DEPTH)
    ) i_cpu_core (
        .clk     (clk),
        .reset_i (reset_i),
        .fetch_i (fetch_i),
        .credit_o(credit_o),
        .commit_o(commit_o)
    );

    always #10 clk = ~clk;

    task automatic fail_run(string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(string name, word_t got, word_t exp);
        fail_run($sformatf("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp));
    endtask

    task automatic check_commit(commit_t got, commit_t exp);
        if (got.pc !== exp.pc) begin
            report_mismatch("commit.pc", got.pc, exp.pc);
        end
        if (got.we !== exp.we) begin
            report_mismatch("commit.we", word_t'(got.we), word_t'(exp.we));
        end
        // Destination fields only carry meaning for a register write
        if (exp.we) begin
            if (got.wnum !== exp.wnum) begin
                report_mismatch("commit.wnum", word_t'(got.wnum), word_t'(exp.wnum));
            end
            if (got.wdata !== exp.wdata) begin
                report_mismatch("commit.wdata", got.wdata, exp.wdata);
            end
        end
    endtask

    task automatic check_credit(int held, credit_t returned);
        if (held < 0 || held > IB_DEPTH) begin
            fail_run($sformatf("Fetcher credit count left its range: %0d held", held));
        end
        if (int'(returned) > ISSUE_WIDTH) begin
            fail_run($sformatf("More credits returned than lanes issue: %0d", returned));
        end
    endtask

    task automatic check_word(string name, word_t got, word_t exp);
        if (got !== exp) begin
            report_mismatch(name, got, exp);
        end
    endtask

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int unsigned take_bits(int n);
        int unsigned v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v = (v << 1) | lfsr_q[0];
        end
        return v;
    endfunction

    function automatic instr_t enc(op_e op, int rd, int rj, int rk, int imm);
        return {op, 5'(rd), 5'(rj), 5'(rk), 2'b00, 12'(imm)};
    endfunction

    // True when the younger entry reads the register the older one writes
    function automatic logic reads_dep(exp_t older, exp_t younger);
        logic src;
        src = (younger.op != OP_NOP) && (younger.op != OP_RSVD);
        return older.c.we && src && ((younger.rj == older.c.wnum) ||
               ((younger.op != OP_ADDI) && (younger.rk == older.c.wnum)));
    endfunction

    // In-order reference model on the shadow register file
    task automatic model_word(instr_t w, word_t pc);
        exp_t  e;
        word_t a;
        word_t b;
        word_t res;
        e.op = op_e'(w[31:29]);
        e.rj = w[23:19];
        e.rk = w[18:14];
        a = shadow[e.rj];
        b = shadow[e.rk];
        case (w[31:29])
            3'd1:    res = a + b;
            3'd2:    res = a - b;
            3'd3:    res = a & b;
            3'd4:    res = a | b;
            3'd5:    res = a ^ b;
            3'd6:    res = a + {{20{w[11]}}, w[11:0]};
            default: res = '0;
        endcase
        e.c.valid = 1'b1;
        e.c.pc    = pc;
        e.c.wnum  = w[28:24];
        e.c.wdata = res;
        e.c.we    = (w[31:29] >= 3'd1) && (w[31:29] <= 3'd6) && (w[28:24] != 5'd0);
        if (e.c.we) begin
            shadow[e.c.wnum] = res;
        end
        exp_q.push_back(e);
    endtask

    task automatic queue_word(instr_t w);
        fetch_slot_t slot;
        model_word(w, pc_next);
        slot.valid = 1'b1;
        slot.pc    = pc_next;
        slot.instr = w;
        pend_q.push_back(slot);
        pc_next = pc_next + 32'd4;
    endtask

    // Random bundle width capped by the credits held
    task automatic send_pending();
        fetch_slot_t [FETCH_WIDTH-1:0] bundle;
        int n;
        int guard;
        guard = 0;
        while (pend_q.size() > 0) begin
            n = int'(take_bits(3));
            if (n > FETCH_WIDTH) begin
                n = FETCH_WIDTH;
            end
            if (n > credits) begin
                n = credits;
            end
            if (n > pend_q.size()) begin
                n = pend_q.size();
            end
            bundle = '0;
            for (int i = 0; i < n; i++) begin
                bundle[i] = pend_q.pop_front();
            end
            fetch_i = bundle;
            @(posedge clk);
            #1;
            guard++;
            if (guard > TIMEOUT) begin
                fail_run("Fetch driver timed out waiting for credits");
            end
        end
        fetch_i = '0;
    endtask

    task automatic wait_drain();
        int guard;
        guard = 0;
        while (exp_q.size() > 0) begin
            @(posedge clk);
            #1;
            guard++;
            if (guard > TIMEOUT) begin
                fail_run("Timed out waiting for outstanding commits");
            end
        end
    endtask

    task automatic add_word(int r, instr_t w);
        prog_tab[r][prog_len[r]] = w;
        prog_len[r]++;
    endtask

    task automatic load_table();
        for (int r = 0; r < N_ROWS; r++) begin
            prog_len[r] = 0;
        end
        // Seeds including negative immediates
        add_word(0, enc(OP_ADDI, 1, 0, 0, 'h123));
        add_word(0, enc(OP_ADDI, 2, 0, 0, 'h456));
        add_word(0, enc(OP_ADDI, 3, 0, 0, -1));
        add_word(0, enc(OP_ADDI, 4, 0, 0, 'h7ff));
        add_word(0, enc(OP_ADDI, 5, 0, 0, -2048));
        add_word(0, enc(OP_ADDI, 6, 0, 0, 'h0f0));
        chk_reg[0] = 5'd5;
        chk_val[0] = 32'hffff_f800;
        // Independent ALU ops that can pair
        add_word(1, enc(OP_ADD, 10, 1, 2, 0));
        add_word(1, enc(OP_SUB, 11, 1, 2, 0));
        add_word(1, enc(OP_AND, 12, 3, 6, 0));
        add_word(1, enc(OP_OR, 13, 1, 6, 0));
        add_word(1, enc(OP_XOR, 14, 2, 6, 0));
        add_word(1, enc(OP_ADD, 15, 4, 5, 0));
        chk_reg[1] = 5'd11;
        chk_val[1] = 32'hffff_fccd;
        add_word(2, enc(OP_ADDI, 16, 1, 0, -5));
        add_word(2, enc(OP_ADDI, 17, 3, 0, -1));
        chk_reg[2] = 5'd16;
        chk_val[2] = 32'h0000_011e;
        // Dependent chain through both forwarding paths
        add_word(3, enc(OP_ADDI, 20, 0, 0, 1));
        add_word(3, enc(OP_ADD, 20, 20, 20, 0));
        add_word(3, enc(OP_ADD, 21, 20, 20, 0));
        add_word(3, enc(OP_SUB, 22, 21, 20, 0));
        add_word(3, enc(OP_XOR, 23, 22, 21, 0));
        add_word(3, enc(OP_OR, 24, 23, 0, 0));
        add_word(3, enc(OP_ADDI, 25, 24, 0, -7));
        chk_reg[3] = 5'd25;
        chk_val[3] = 32'hffff_ffff;
        // r0 writes, NOP and reserved op
        add_word(4, enc(OP_ADD, 0, 1, 2, 0));
        add_word(4, enc(OP_ADD, 27, 0, 1, 0));
        add_word(4, enc(OP_NOP, 0, 0, 0, 0));
        add_word(4, enc(OP_RSVD, 28, 1, 2, 0));
        add_word(4, enc(OP_ADDI, 0, 0, 0, 5));
        add_word(4, enc(OP_OR, 28, 0, 0, 0));
        add_word(4, enc(OP_ADD, 29, 27, 0, 0));
        chk_reg[4] = 5'd29;
        chk_val[4] = 32'h0000_0123;
    endtask

    // Credit accounting and commit monitor sampled mid-cycle
    always @(negedge clk) begin
        int   n_valid;
        exp_t e0;
        exp_t e1;
        if (!reset_i) begin
            if (total_sent == 0 && credit_o != '0) begin
                fail_run("Credit returned before any instruction was fetched");
            end
            n_valid = 0;
            for (int i = 0; i < FETCH_WIDTH; i++) begin
                if (fetch_i[i].valid) begin
                    n_valid++;
                end
            end
            total_sent   += n_valid;
            total_credit += int'(credit_o);
            credits = credits - n_valid + int'(credit_o);
            check_credit(credits, credit_o);
            for (int l = 0; l < ISSUE_WIDTH; l++) begin
                if (commit_o[l].valid) begin
                    if (exp_q.size() == 0) begin
                        fail_run($sformatf("Commit on lane %0d with nothing outstanding", l));
                    end
                    e1 = exp_q.pop_front();
                    if (l == 1 && commit_o[0].valid && reads_dep(e0, e1)) begin
                        fail_run("Dependent pair committed in the same cycle");
                    end
                    check_commit(commit_o[l], e1.c);
                    if (commit_o[l].we) begin
                        committed[commit_o[l].wnum] = commit_o[l].wdata;
                    end
                    total_commit++;
                    e0 = e1;
                end
            end
            if (commit_o[0].valid && commit_o[1].valid) begin
                total_pairs++;
            end
        end
    end

    initial begin
        int unsigned op;
        int unsigned rd;
        int unsigned rj;
        int unsigned rk;
        int unsigned imm;
        reset_i = 1'b1;
        fetch_i = '0;
        for (int r = 0; r < 32; r++) begin
            shadow[r]    = '0;
            committed[r] = '0;
        end
        load_table();
        repeat (3) @(posedge clk);
        #1;
        reset_i = 1'b0;
        // Quiet cycles before the first fetch
        repeat (5) @(posedge clk);
        #1;
        for (int r = 0; r < N_ROWS; r++) begin
            for (int i = 0; i < prog_len[r]; i++) begin
                queue_word(prog_tab[r][i]);
            end
            send_pending();
            wait_drain();
            check_word($sformatf("r%0d", chk_reg[r]), committed[chk_reg[r]], chk_val[r]);
        end
        // Dense random stream over r0..r7
        for (int i = 0; i < N_RANDOM; i++) begin
            op  = take_bits(3);
            rd  = take_bits(3);
            rj  = take_bits(3);
            rk  = take_bits(3);
            imm = take_bits(12);
            queue_word(enc(op_e'(3'(op)), int'(rd), int'(rj), int'(rk), int'(imm)));
        end
        send_pending();
        wait_drain();
        check_word("credits held", word_t'(credits), word_t'(IB_DEPTH));
        check_word("credits returned", word_t'(total_credit), word_t'(total_sent));
        check_word("commit count", word_t'(total_commit), word_t'(total_sent));
        if (total_pairs == 0) begin
            fail_run("No two instructions ever committed in the same cycle");
        end
        $display("Regression passed");
        $finish;
    end

endmodule

/* bench/cpu_core_sva.sv */
`timescale 1ns/10ps

module cpu_core_sva
    import core_pkg::*;
#(
    parameter int IB_DEPTH = core_pkg::IB_DEPTH
) (
    input logic                          clk,
    input logic                          reset_i,
    input logic [$clog2(IB_DEPTH+1)-1:0] count_i,
    input credit_t                       credit_i,
    input commit_t [ISSUE_WIDTH-1:0]     commit_i
);

    // Fetcher must never overrun the buffer
    assert property (@(posedge clk) disable iff (reset_i) count_i <= IB_DEPTH)
        else $error("instruction buffer count %0d above depth", count_i);

    // Lane 0 always holds the older commit
    assert property (@(posedge clk) disable iff (reset_i)
                     commit_i[1].valid |-> commit_i[0].valid)
        else $error("lane 1 committed without lane 0");

    assert property (@(posedge clk) (reset_i && $past(reset_i)) |-> (credit_i == '0))
        else $error("credit returned while in reset");

endmodule

bind cpu_core cpu_core_sva #(.IB_DEPTH(IB_DEPTH)) i_cpu_core_sva (
    .clk     (clk),
    .reset_i (reset_i),
    .count_i (ib_count),
    .credit_i(credit_o),
    .commit_i(commit_o)
);

/* rtl/cpu_core.sv */
`timescale 1ns/10ps

module cpu_core
    import core_pkg::*;
#(
    parameter int FETCH_WIDTH = core_pkg::FETCH_WIDTH,
    parameter int IB_DEPTH    = core_pkg::IB_DEPTH
) (
    input  logic                          clk,
    input  logic                          reset_i,
    input  fetch_slot_t [FETCH_WIDTH-1:0] fetch_i,
    output credit_t                       credit_o,
    output commit_t     [ISSUE_WIDTH-1:0] commit_o
);

    localparam int CNT_W = $clog2(IB_DEPTH + 1);

    fetch_slot_t [ISSUE_WIDTH-1:0]   ib_head;
    logic        [CNT_W-1:0]         ib_count;
    logic        [1:0]               accept;
    uop_t        [ISSUE_WIDTH-1:0]   uop;
    reg_addr_t   [2*ISSUE_WIDTH-1:0] rf_raddr;
    word_t       [2*ISSUE_WIDTH-1:0] rf_rdata;
    issue_t      [ISSUE_WIDTH-1:0]   issue;
    result_t     [ISSUE_WIDTH-1:0]   ex_fwd;
    result_t     [ISSUE_WIDTH-1:0]   wb;

    instr_buffer #(
        .FETCH_WIDTH(FETCH_WIDTH),
        .IB_DEPTH   (IB_DEPTH)
    ) u_instr_buffer (
        .clk     (clk),
        .reset_i (reset_i),
        .fetch_i (fetch_i),
        .accept_i(accept),
        .head_o  (ib_head),
        .count_o (ib_count),
        .credit_o(credit_o)
    );

    decode_issue #(
        .IB_DEPTH(IB_DEPTH)
    ) u_decode_issue (
        .head_i  (ib_head),
        .count_i (ib_count),
        .uop_o   (uop),
        .accept_o(accept)
    );

    dispatch_stage u_dispatch_stage (
        .clk       (clk),
        .reset_i   (reset_i),
        .uop_i     (uop),
        .ex_fwd_i  (ex_fwd),
        .wb_i      (wb),
        .rf_raddr_o(rf_raddr),
        .rf_rdata_i(rf_rdata),
        .issue_o   (issue)
    );

    exec_stage u_exec_stage (
        .clk     (clk),
        .reset_i (reset_i),
        .issue_i (issue),
        .ex_fwd_o(ex_fwd),
        .wb_o    (wb)
    );

    regfile u_regfile (
        .clk    (clk),
        .reset_i(reset_i),
        .wb_i   (wb),
        .raddr_i(rf_raddr),
        .rdata_o(rf_rdata)
    );

    // Write-back records double as the commit debug ports
    for (genvar l = 0; l < ISSUE_WIDTH; l++) begin : g_commit
        assign commit_o[l].valid = wb[l].valid;
        assign commit_o[l].we    = wb[l].we;
        assign commit_o[l].pc    = wb[l].pc;
        assign commit_o[l].wnum  = wb[l].rd;
        assign commit_o[l].wdata = wb[l].data;
    end

endmodule

/* rtl/regfile.sv */
`timescale 1ns/10ps

module regfile
    import core_pkg::*;
(
    input  logic                             clk,
    input  logic                             reset_i,
    input  result_t   [ISSUE_WIDTH-1:0]      wb_i,
    input  reg_addr_t [2*ISSUE_WIDTH-1:0]    raddr_i,
    output word_t     [2*ISSUE_WIDTH-1:0]    rdata_o
);

    localparam int NUM_REGS = 32;

    word_t regs [NUM_REGS];

    // Lane 1 is assigned last and wins on the same register
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int l = 0; l < ISSUE_WIDTH; l++) begin
                if (wb_i[l].valid && wb_i[l].we && (wb_i[l].rd != '0)) begin
                    regs[wb_i[l].rd] <= wb_i[l].data;
                end
            end
        end
    end

    always_comb begin
        for (int p = 0; p < 2*ISSUE_WIDTH; p++) begin
            rdata_o[p] = (raddr_i[p] == '0) ? '0 : regs[raddr_i[p]];
        end
    end

endmodule

/* rtl/exec_stage.sv */
`timescale 1ns/10ps

module exec_stage
    import core_pkg::*;
(
    input  logic                        clk,
    input  logic                        reset_i,
    input  issue_t  [ISSUE_WIDTH-1:0]   issue_i,
    output result_t [ISSUE_WIDTH-1:0]   ex_fwd_o,
    output result_t [ISSUE_WIDTH-1:0]   wb_o
);

    function automatic word_t alu(op_e op, word_t a, word_t b);
        word_t res;
        case (op)
            OP_ADD, OP_ADDI: res = a + b;
            OP_SUB:          res = a - b;
            OP_AND:          res = a & b;
            OP_OR:           res = a | b;
            OP_XOR:          res = a ^ b;
            default:         res = '0;
        endcase
        return res;
    endfunction

    // Results of the packet in execute, visible to dispatch this cycle
    always_comb begin
        for (int l = 0; l < ISSUE_WIDTH; l++) begin
            ex_fwd_o[l].valid = issue_i[l].valid;
            ex_fwd_o[l].we    = issue_i[l].valid && issue_i[l].we;
            ex_fwd_o[l].rd    = issue_i[l].rd;
            ex_fwd_o[l].pc    = issue_i[l].pc;
            ex_fwd_o[l].data  = alu(issue_i[l].op, issue_i[l].a, issue_i[l].b);
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int l = 0; l < ISSUE_WIDTH; l++) begin
                wb_o[l].valid <= 1'b0;
                wb_o[l].we    <= 1'b0;
            end
        end else begin
            wb_o <= ex_fwd_o;
        end
    end

endmodule

/* rtl/dispatch_stage.sv */
`timescale 1ns/10ps

module dispatch_stage
    import core_pkg::*;
(
    input  logic                             clk,
    input  logic                             reset_i,
    input  uop_t      [ISSUE_WIDTH-1:0]      uop_i,
    input  result_t   [ISSUE_WIDTH-1:0]      ex_fwd_i,
    input  result_t   [ISSUE_WIDTH-1:0]      wb_i,
    output reg_addr_t [2*ISSUE_WIDTH-1:0]    rf_raddr_o,
    input  word_t     [2*ISSUE_WIDTH-1:0]    rf_rdata_i,
    output issue_t    [ISSUE_WIDTH-1:0]      issue_o
);

    issue_t [ISSUE_WIDTH-1:0] issue_d;

    function automatic logic hit(result_t r, reg_addr_t addr);
        return r.valid && r.we && (r.rd == addr);
    endfunction

    // Later matches override earlier ones, so execute lane 1 ends up highest
    function automatic word_t select_operand(reg_addr_t addr, word_t rf_val,
                                             result_t [ISSUE_WIDTH-1:0] ex_fwd,
                                             result_t [ISSUE_WIDTH-1:0] wb);
        word_t val;
        val = rf_val;
        for (int l = 0; l < ISSUE_WIDTH; l++) begin
            if (hit(wb[l], addr)) begin
                val = wb[l].data;
            end
        end
        for (int l = 0; l < ISSUE_WIDTH; l++) begin
            if (hit(ex_fwd[l], addr)) begin
                val = ex_fwd[l].data;
            end
        end
        return val;
    endfunction

    always_comb begin
        for (int l = 0; l < ISSUE_WIDTH; l++) begin
            rf_raddr_o[2*l]     = uop_i[l].rj;
            rf_raddr_o[2*l + 1] = uop_i[l].rk;

            issue_d[l].valid = uop_i[l].valid;
            issue_d[l].op    = uop_i[l].op;
            issue_d[l].we    = uop_i[l].we;
            issue_d[l].rd    = uop_i[l].rd;
            issue_d[l].pc    = uop_i[l].pc;
            issue_d[l].a     = select_operand(uop_i[l].rj, rf_rdata_i[2*l], ex_fwd_i, wb_i);
            if (uop_i[l].op == OP_ADDI) begin
                issue_d[l].b = uop_i[l].imm;
            end else begin
                issue_d[l].b = select_operand(uop_i[l].rk, rf_rdata_i[2*l + 1],
                                              ex_fwd_i, wb_i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int l = 0; l < ISSUE_WIDTH; l++) begin
                issue_o[l].valid <= 1'b0;
            end
        end else begin
            issue_o <= issue_d;
        end
    end

endmodule

/* rtl/decode_issue.sv */
`timescale 1ns/10ps

module decode_issue
    import core_pkg::*;
#(
    parameter int IB_DEPTH = core_pkg::IB_DEPTH
) (
    input  fetch_slot_t [ISSUE_WIDTH-1:0]        head_i,
    input  logic        [$clog2(IB_DEPTH+1)-1:0] count_i,
    output uop_t        [ISSUE_WIDTH-1:0]        uop_o,
    output logic        [1:0]                    accept_o
);

    uop_t [ISSUE_WIDTH-1:0] dec;
    logic                   lane0_present;
    logic                   lane1_present;
    logic                   raw_hazard;
    logic                   pair;

    function automatic uop_t decode(fetch_slot_t slot);
        uop_t u;
        u.valid = 1'b0;
        u.op    = op_e'(slot.instr[31:29]);
        // Reserved opcode behaves as NOP
        if (u.op == OP_RSVD) begin
            u.op = OP_NOP;
        end
        u.rd  = slot.instr[28:24];
        u.rj  = slot.instr[23:19];
        u.rk  = slot.instr[18:14];
        u.imm = {{20{slot.instr[11]}}, slot.instr[11:0]};
        u.pc  = slot.pc;
        u.we  = (u.op != OP_NOP) && (u.rd != '0);
        return u;
    endfunction

    always_comb begin
        for (int l = 0; l < ISSUE_WIDTH; l++) begin
            dec[l] = decode(head_i[l]);
        end

        lane0_present = head_i[0].valid;
        lane1_present = head_i[1].valid && (count_i >= 2);

        // Lane 1 must not read what lane 0 writes; ADDI has no rk source
        raw_hazard = dec[0].we &&
                     (((dec[1].op != OP_NOP) && (dec[1].rj == dec[0].rd)) ||
                      ((dec[1].op != OP_NOP) && (dec[1].op != OP_ADDI) &&
                       (dec[1].rk == dec[0].rd)));
        pair = lane0_present && lane1_present && !raw_hazard;

        uop_o          = dec;
        uop_o[0].valid = lane0_present;
        uop_o[0].we    = dec[0].we && lane0_present;
        uop_o[1].valid = pair;
        uop_o[1].we    = dec[1].we && pair;

        accept_o = pair ? 2'd2 : (lane0_present ? 2'd1 : 2'd0);
    end

endmodule

/* rtl/instr_buffer.sv */
`timescale 1ns/10ps

module instr_buffer
    import core_pkg::*;
#(
    parameter int FETCH_WIDTH = core_pkg::FETCH_WIDTH,
    parameter int IB_DEPTH    = core_pkg::IB_DEPTH
) (
    input  logic                                 clk,
    input  logic                                 reset_i,
    input  fetch_slot_t [FETCH_WIDTH-1:0]        fetch_i,
    input  logic        [1:0]                    accept_i,
    output fetch_slot_t [ISSUE_WIDTH-1:0]        head_o,
    output logic        [$clog2(IB_DEPTH+1)-1:0] count_o,
    output credit_t                              credit_o
);

    localparam int PTR_W = $clog2(IB_DEPTH);
    localparam int CNT_W = $clog2(IB_DEPTH + 1);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [CNT_W-1:0] cnt_t;

    fetch_slot_t slot_mem [IB_DEPTH];
    ptr_t        head_q;
    ptr_t        tail_q;
    cnt_t        count_q;
    cnt_t        fetch_cnt;

    // Pointer advance with wrap, step never exceeds the depth
    function automatic ptr_t ptr_add(ptr_t base, int unsigned step);
        int unsigned sum;
        sum = int'(base) + step;
        if (sum >= IB_DEPTH) begin
            sum = sum - IB_DEPTH;
        end
        return ptr_t'(sum);
    endfunction

    // Valid slots form a prefix, so the last valid index gives the count
    always_comb begin
        fetch_cnt = '0;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            if (fetch_i[i].valid) begin
                fetch_cnt = cnt_t'(i + 1);
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            if (fetch_i[i].valid) begin
                slot_mem[ptr_add(tail_q, i)] <= fetch_i[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            head_q  <= ptr_add(head_q, accept_i);
            tail_q  <= ptr_add(tail_q, fetch_cnt);
            count_q <= count_q + fetch_cnt - cnt_t'(accept_i);
        end
    end

    // Oldest entries, valid only while occupied
    always_comb begin
        for (int k = 0; k < ISSUE_WIDTH; k++) begin
            head_o[k]       = slot_mem[ptr_add(head_q, k)];
            head_o[k].valid = (count_q > k);
        end
    end

    assign count_o  = count_q;
    assign credit_o = credit_t'(accept_i);

endmodule

/* rtl/core_pkg.sv */
package core_pkg;

    // Default widths of the fetch and issue paths
    localparam int FETCH_WIDTH = 4;
    localparam int ISSUE_WIDTH = 2;
    localparam int IB_DEPTH    = 8;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [31:0] instr_t;

    // Entries freed per cycle, sized to hold a full fetch bundle
    typedef logic [$clog2(FETCH_WIDTH + 1)-1:0] credit_t;

    typedef enum logic [2:0] {
        OP_NOP  = 3'd0,
        OP_ADD  = 3'd1,
        OP_SUB  = 3'd2,
        OP_AND  = 3'd3,
        OP_OR   = 3'd4,
        OP_XOR  = 3'd5,
        OP_ADDI = 3'd6,
        OP_RSVD = 3'd7
    } op_e;

    typedef struct packed {
        logic   valid;
        word_t  pc;
        instr_t instr;
    } fetch_slot_t;

    // Decoded lane, imm already sign-extended
    typedef struct packed {
        logic      valid;
        op_e       op;
        logic      we;
        reg_addr_t rd;
        reg_addr_t rj;
        reg_addr_t rk;
        word_t     imm;
        word_t     pc;
    } uop_t;

    typedef struct packed {
        logic      valid;
        op_e       op;
        logic      we;
        reg_addr_t rd;
        word_t     pc;
        word_t     a;
        word_t     b;
    } issue_t;

    // Result of one lane, also used as a forwarding source
    typedef struct packed {
        logic      valid;
        logic      we;
        reg_addr_t rd;
        word_t     pc;
        word_t     data;
    } result_t;

    typedef struct packed {
        logic      valid;
        logic      we;
        word_t     pc;
        reg_addr_t wnum;
        word_t     wdata;
    } commit_t;

endpackage
